// ==== logic/board_pkg.sv ====
// Widths, bit positions and structs for the input block. BUTTONS above 2 shifts start, coin and pause up
`default_nettype none

package board_pkg;

    localparam int NUM_PLAYERS = 4;
    localparam int KEY_PLAYERS = 3;
    localparam int BOARD_JOY_W = 16;
    localparam int GAME_JOY_W  = 10;
    localparam int DIR_W       = 4;
    localparam int BUTTONS     = 2;
    localparam int GFX_LAYERS  = 4;

    // board joystick bits just above the game buttons
    localparam int START_BIT = 6 + (BUTTONS - 2);
    localparam int COIN_BIT  = 7 + (BUTTONS - 2);
    localparam int PAUSE_BIT = 8 + (BUTTONS - 2);

    // direction bits inside a joystick word
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    localparam bit INPUTS_ACTIVE_LOW = 1'b1;

    typedef logic [BOARD_JOY_W-1:0] board_joy_t;
    typedef logic [GAME_JOY_W-1:0]  game_joy_t;

    // keys already decoded from the keyboard, player 1 in slot 0
    typedef struct packed {
        game_joy_t [KEY_PLAYERS-1:0] key_joy;
        logic [NUM_PLAYERS-1:0]      key_start;
        logic [NUM_PLAYERS-1:0]      key_coin;
        logic                        key_reset;
        logic                        key_pause;
        logic                        key_service;
        logic [GFX_LAYERS-1:0]       key_gfx;
    } key_inputs_t;

    typedef struct packed {
        game_joy_t [NUM_PLAYERS-1:0] joystick;
        logic [NUM_PLAYERS-1:0]      coin;
        logic [NUM_PLAYERS-1:0]      start;
        logic                        service;
    } game_inputs_t;

    typedef struct packed {
        logic rot_control;
        logic flip;
        logic en4way;
    } screen_cfg_t;

    // every game input released
    localparam game_inputs_t GAME_IDLE =
        game_inputs_t'({$bits(game_inputs_t){INPUTS_ACTIVE_LOW}});

endpackage

`default_nettype wire

// ==== logic/four_way_filter.sv ====
// Registered 4-way filter with one cycle of latency. Diagonals repeat the last single direction seen in 4-way mode
`default_nettype none

module four_way_filter import board_pkg::*; (
    input  logic             clk_sys,
    input  logic             rst,
    input  logic             en4way,
    input  logic [DIR_W-1:0] dir_in,
    output logic [DIR_W-1:0] dir_out
);

    logic [DIR_W-1:0] last_dir;
    logic             idle;
    logic             single;

    assign idle = (dir_in == '0);

    // clearing the lowest set bit leaves zero only for one-hot values
    assign single = !idle && ((dir_in & (dir_in - 1'b1)) == '0);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            dir_out  <= '0;
            last_dir <= '0;
        end else if (!en4way) begin
            // 8-way mode passes everything
            dir_out <= dir_in;
        end else if (single) begin
            dir_out  <= dir_in;
            last_dir <= dir_in;
        end else if (idle) begin
            dir_out <= '0;
        end else begin
            // diagonal
            dir_out <= last_dir;
        end
    end

endmodule

`default_nettype wire

// ==== logic/input_mapper.sv ====
// Board joysticks are taken as already in the clk_sys domain. Flip only matters while rot_control is set
`default_nettype none

module input_mapper import board_pkg::*; (
    input  logic                              clk_sys,
    input  logic                              rst,
    input  board_joy_t [NUM_PLAYERS-1:0]      board_joy,
    input  logic [NUM_PLAYERS-1:0][DIR_W-1:0] dir_filt,
    input  key_inputs_t                       keys,
    input  logic                              rot_control,
    input  logic                              flip,
    output game_inputs_t                      game,
    output logic                              joy_pause
);

    board_joy_t [NUM_PLAYERS-1:0] joy_sync;
    game_joy_t [NUM_PLAYERS-1:0]  key_joy_all;
    game_inputs_t                 game_next;

    // only the direction bits move, buttons stay in place
    function automatic game_joy_t rotate_dirs(input game_joy_t joy, input logic rot,
                                              input logic flp);
        game_joy_t res;
        res = joy;
        if (rot) begin
            if (flp) begin
                res[DIR_UP]    = joy[DIR_LEFT];
                res[DIR_DOWN]  = joy[DIR_RIGHT];
                res[DIR_LEFT]  = joy[DIR_DOWN];
                res[DIR_RIGHT] = joy[DIR_UP];
            end else begin
                res[DIR_UP]    = joy[DIR_RIGHT];
                res[DIR_DOWN]  = joy[DIR_LEFT];
                res[DIR_LEFT]  = joy[DIR_UP];
                res[DIR_RIGHT] = joy[DIR_DOWN];
            end
        end
        return res;
    endfunction

    // players without keyboard keys get zeros
    assign key_joy_all = {{((NUM_PLAYERS - KEY_PLAYERS) * GAME_JOY_W){1'b0}}, keys.key_joy};

    // sync stage, directions come from the filters already registered
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            joy_sync <= '0;
        end else begin
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                joy_sync[p] <= {board_joy[p][BOARD_JOY_W-1:DIR_W], dir_filt[p]};
            end
        end
    end

    assign joy_pause = joy_sync[0][PAUSE_BIT] | joy_sync[1][PAUSE_BIT];

    always_comb begin
        game_joy_t merged;
        game_next = GAME_IDLE;
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            merged = joy_sync[p][GAME_JOY_W-1:0] | key_joy_all[p];
            game_next.joystick[p] = {GAME_JOY_W{INPUTS_ACTIVE_LOW}}
                                    ^ rotate_dirs(merged, rot_control, flip);
            game_next.coin[p]  = INPUTS_ACTIVE_LOW
                                 ^ (joy_sync[p][COIN_BIT] | keys.key_coin[p]);
            game_next.start[p] = INPUTS_ACTIVE_LOW
                                 ^ (joy_sync[p][START_BIT] | keys.key_start[p]);
        end
        game_next.service = INPUTS_ACTIVE_LOW ^ keys.key_service;
    end

    // output stage
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game <= GAME_IDLE;
        end else begin
            game <= game_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/board_control.sv ====
// Pause, soft reset and layer enables react to rising edges only. downloading overrides every pause source
`default_nettype none

module board_control import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  key_pause,
    input  logic                  key_reset,
    input  logic [GFX_LAYERS-1:0] key_gfx,
    input  logic                  joy_pause,
    input  logic                  osd_pause,
    input  logic                  downloading,
    output logic                  game_pause,
    output logic                  soft_rst,
    output logic [GFX_LAYERS-1:0] gfx_en
);

    logic                  last_key_pause;
    logic                  last_joy_pause;
    logic                  last_osd_pause;
    logic                  last_reset;
    logic [GFX_LAYERS-1:0] last_gfx;
    logic                  pause_rise;
    logic                  osd_change;
    logic [GFX_LAYERS-1:0] gfx_rise;

    assign pause_rise = (key_pause & ~last_key_pause) | (joy_pause & ~last_joy_pause);
    assign osd_change = osd_pause ^ last_osd_pause;
    assign gfx_rise   = key_gfx & ~last_gfx;

    // edge history
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_reset     <= 1'b0;
            last_gfx       <= '0;
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= joy_pause;
            last_osd_pause <= osd_pause;
            last_reset     <= key_reset;
            last_gfx       <= key_gfx;
        end
    end

    // the OSD setting wins over a toggle in the same cycle
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
        end else if (downloading) begin
            game_pause <= 1'b0;
        end else if (osd_change) begin
            game_pause <= osd_pause;
        end else if (pause_rise) begin
            game_pause <= ~game_pause;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst <= 1'b0;
            gfx_en   <= '1;
        end else begin
            soft_rst <= key_reset & ~last_reset;
            gfx_en   <= gfx_en ^ gfx_rise;
        end
    end

endmodule

`default_nettype wire

// ==== logic/board_inputs.sv ====
// Single clk_sys domain with synchronous active-high reset. Keyboard decoding and DIP decoding live outside
`default_nettype none

module board_inputs import board_pkg::*; (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  board_joy_t [NUM_PLAYERS-1:0] board_joy,
    input  key_inputs_t                  keys,
    input  screen_cfg_t                  cfg,
    input  logic                         osd_pause,
    input  logic                         downloading,
    output game_inputs_t                 game,
    output logic                         game_pause,
    output logic                         soft_rst,
    output logic [GFX_LAYERS-1:0]        gfx_en
);

    logic [NUM_PLAYERS-1:0][DIR_W-1:0] dir_filt;
    logic                              joy_pause;

    // one filter per player on the raw direction bits
    for (genvar p = 0; p < NUM_PLAYERS; p++) begin : u_4way
        four_way_filter u_filter (
            .clk_sys ( clk_sys                  ),
            .rst     ( rst                      ),
            .en4way  ( cfg.en4way               ),
            .dir_in  ( board_joy[p][DIR_W-1:0]  ),
            .dir_out ( dir_filt[p]              )
        );
    end

    input_mapper u_mapper (
        .clk_sys     ( clk_sys         ),
        .rst         ( rst             ),
        .board_joy   ( board_joy       ),
        .dir_filt    ( dir_filt        ),
        .keys        ( keys            ),
        .rot_control ( cfg.rot_control ),
        .flip        ( cfg.flip        ),
        .game        ( game            ),
        .joy_pause   ( joy_pause       )
    );

    board_control u_control (
        .clk_sys     ( clk_sys         ),
        .rst         ( rst             ),
        .key_pause   ( keys.key_pause  ),
        .key_reset   ( keys.key_reset  ),
        .key_gfx     ( keys.key_gfx    ),
        .joy_pause   ( joy_pause       ),
        .osd_pause   ( osd_pause       ),
        .downloading ( downloading     ),
        .game_pause  ( game_pause      ),
        .soft_rst    ( soft_rst        ),
        .gfx_en      ( gfx_en          )
    );

endmodule

`default_nettype wire

// ==== tests/board_control_assert.sv ====
// Bound into board_control. Needs rst driven from time zero, checks hold only on clk_sys edges
`default_nettype none

module board_control_assert import board_pkg::*; (
    input logic                  clk_sys,
    input logic                  rst,
    input logic                  downloading,
    input logic                  game_pause,
    input logic                  soft_rst,
    input logic [GFX_LAYERS-1:0] gfx_en
);

    timeunit 1ns;
    timeprecision 100ps;

    // one-cycle pulse only
    property soft_rst_single;
        @(posedge clk_sys) disable iff (rst) soft_rst |=> !soft_rst;
    endproperty

    // download always forces the game out of pause
    property pause_cleared_by_download;
        @(posedge clk_sys) disable iff (rst) downloading |=> !game_pause;
    endproperty

    property gfx_enabled_after_reset;
        @(posedge clk_sys) rst |=> (gfx_en == '1);
    endproperty

    a_soft_rst_single: assert property (soft_rst_single)
        else $error("soft_rst high on two consecutive cycles");

    a_pause_cleared: assert property (pause_cleared_by_download)
        else $error("game_pause set on the cycle after downloading");

    a_gfx_reset: assert property (gfx_enabled_after_reset)
        else $error("gfx_en not all ones on the cycle after reset");

endmodule

`default_nettype wire

// ==== tests/board_inputs_tb.sv ====
// Seeded random run against a cycle model. Inputs move 2 ns after each edge, outputs are checked 1 ns after it
`default_nettype none

module board_inputs_tb import board_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic                         clk_sys;
    logic                         rst;
    board_joy_t [NUM_PLAYERS-1:0] board_joy;
    key_inputs_t                  keys;
    screen_cfg_t                  cfg;
    logic                         osd_pause;
    logic                         downloading;
    game_inputs_t                 game;
    logic                         game_pause;
    logic                         soft_rst;
    logic [GFX_LAYERS-1:0]        gfx_en;

    integer seed;
    int     seen_pause;
    int     seen_soft_rst;

    // reference model state
    logic [NUM_PLAYERS-1:0][DIR_W-1:0] m_filt;
    logic [NUM_PLAYERS-1:0][DIR_W-1:0] m_mem;
    board_joy_t [NUM_PLAYERS-1:0]      m_sync;
    game_inputs_t                      m_game;
    logic                              m_pause;
    logic                              m_soft_rst;
    logic [GFX_LAYERS-1:0]             m_gfx_en;
    logic                              m_last_kp;
    logic                              m_last_jp;
    logic                              m_last_osd;
    logic                              m_last_rst;
    logic [GFX_LAYERS-1:0]             m_last_gfx;

    board_inputs dut0 (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .board_joy   ( board_joy   ),
        .keys        ( keys        ),
        .cfg         ( cfg         ),
        .osd_pause   ( osd_pause   ),
        .downloading ( downloading ),
        .game        ( game        ),
        .game_pause  ( game_pause  ),
        .soft_rst    ( soft_rst    ),
        .gfx_en      ( gfx_en      )
    );

    bind board_control board_control_assert u_control_assert (
        .clk_sys     ( clk_sys     ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .game_pause  ( game_pause  ),
        .soft_rst    ( soft_rst    ),
        .gfx_en      ( gfx_en      )
    );

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    function automatic bit chance(input int pct);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'd100) < pct;
    endfunction

    // half single directions, a quarter idle, a quarter anything (mostly diagonals)
    function automatic logic [DIR_W-1:0] pick_dir();
        logic [31:0] r;
        r = $random(seed);
        if (r[4] == 1'b0) begin
            return 4'b0001 << r[1:0];
        end else if (r[3] == 1'b0) begin
            return 4'b0000;
        end
        return r[11:8];
    endfunction

    // returned order is up, down, left, right
    function automatic logic [DIR_W-1:0] turn_dirs(input logic [DIR_W-1:0] d, input logic rot,
                                                   input logic flp);
        if (!rot) begin
            return d;
        end else if (flp) begin
            return {d[1], d[0], d[2], d[3]};
        end
        return {d[0], d[1], d[3], d[2]};
    endfunction

    task automatic model_step();
        logic [NUM_PLAYERS-1:0][DIR_W-1:0] n_filt;
        logic [NUM_PLAYERS-1:0][DIR_W-1:0] n_mem;
        board_joy_t [NUM_PLAYERS-1:0]      n_sync;
        game_inputs_t                      n_game;
        game_joy_t                         joy;
        logic [DIR_W-1:0]                  dir;
        logic                              jp;
        if (rst) begin
            m_filt     = '0;
            m_mem      = '0;
            m_sync     = '0;
            m_game     = {$bits(game_inputs_t){1'b1}};
            m_pause    = 1'b0;
            m_soft_rst = 1'b0;
            m_gfx_en   = '1;
            m_last_kp  = 1'b0;
            m_last_jp  = 1'b0;
            m_last_osd = 1'b0;
            m_last_rst = 1'b0;
            m_last_gfx = '0;
        end else begin
            n_mem = m_mem;
            for (int p = 0; p < NUM_PLAYERS; p++) begin
                dir = board_joy[p][DIR_W-1:0];
                if (!cfg.en4way || $countones(dir) == 1) begin
                    n_filt[p] = dir;
                    if (cfg.en4way) n_mem[p] = dir;
                end else if (dir == '0) begin
                    n_filt[p] = '0;
                end else begin
                    n_filt[p] = m_mem[p];
                end
                n_sync[p] = {board_joy[p][BOARD_JOY_W-1:DIR_W], m_filt[p]};
                joy = m_sync[p][GAME_JOY_W-1:0];
                if (p < KEY_PLAYERS) joy = joy | keys.key_joy[p];
                joy[DIR_W-1:0] = turn_dirs(joy[DIR_W-1:0], cfg.rot_control, cfg.flip);
                n_game.joystick[p] = ~joy;
                n_game.coin[p]     = ~(m_sync[p][COIN_BIT] | keys.key_coin[p]);
                n_game.start[p]    = ~(m_sync[p][START_BIT] | keys.key_start[p]);
            end
            n_game.service = ~keys.key_service;
            jp = m_sync[0][PAUSE_BIT] | m_sync[1][PAUSE_BIT];
            if (downloading) begin
                m_pause = 1'b0;
            end else if (osd_pause != m_last_osd) begin
                m_pause = osd_pause;
            end else if ((keys.key_pause && !m_last_kp) || (jp && !m_last_jp)) begin
                m_pause = !m_pause;
            end
            m_soft_rst = keys.key_reset && !m_last_rst;
            m_gfx_en   = m_gfx_en ^ (keys.key_gfx & ~m_last_gfx);
            m_last_kp  = keys.key_pause;
            m_last_jp  = jp;
            m_last_osd = osd_pause;
            m_last_rst = keys.key_reset;
            m_last_gfx = keys.key_gfx;
            m_filt     = n_filt;
            m_mem      = n_mem;
            m_sync     = n_sync;
            m_game     = n_game;
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic compare_all();
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            check_value($sformatf("game.joystick[%0d]", p), 64'(game.joystick[p]),
                        64'(m_game.joystick[p]));
        end
        check_value("game.coin", 64'(game.coin), 64'(m_game.coin));
        check_value("game.start", 64'(game.start), 64'(m_game.start));
        check_value("game.service", 64'(game.service), 64'(m_game.service));
        check_value("game_pause", 64'(game_pause), 64'(m_pause));
        check_value("soft_rst", 64'(soft_rst), 64'(m_soft_rst));
        check_value("gfx_en", 64'(gfx_en), 64'(m_gfx_en));
    endtask

    // returns 2 ns after the edge when the next drive is due
    task automatic run_cycle();
        @(posedge clk_sys);
        model_step();
        #1;
        compare_all();
        if (game_pause) seen_pause++;
        if (soft_rst) seen_soft_rst++;
        #1;
    endtask

    task automatic wait_outputs_idle();
        int waited;
        waited = 0;
        while (!(game_pause === 1'b0 && soft_rst === 1'b0 && gfx_en === 4'hf)) begin
            if (waited == 10) begin
                $display("timeout: control outputs did not settle after reset");
                $display("TEST FAIL");
                $fatal(1, "stopped on timeout");
            end else begin
                run_cycle();
                waited++;
            end
        end
    endtask

    task automatic drive_inputs(input int mode);
        logic [31:0] r;
        logic        kp;
        case (mode)
            // directions only with cfg chosen by the caller
            0: begin
                for (int p = 0; p < NUM_PLAYERS; p++) board_joy[p] = {12'h000, pick_dir()};
                r = $random(seed);
                keys = '0;
                if (chance(20)) keys.key_joy = r[29:0];
            end
            1: begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    r = $random(seed);
                    board_joy[p] = {r[15:4], pick_dir()};
                end
                r = $random(seed);
                keys.key_joy = r[29:0];
                r = $random(seed);
                keys.key_start   = r[3:0];
                keys.key_coin    = r[7:4];
                keys.key_reset   = r[8];
                keys.key_pause   = r[9];
                keys.key_service = r[10];
                keys.key_gfx     = r[14:11];
                cfg              = r[17:15];
            end
            // pause bits of players 3 and 4 are driven too and must not matter
            2: begin
                for (int p = 0; p < NUM_PLAYERS; p++) begin
                    board_joy[p] = '0;
                    board_joy[p][PAUSE_BIT] = chance(p < 2 ? 25 : 50);
                end
                kp = keys.key_pause;
                keys = '0;
                keys.key_pause = chance(30) ? ~kp : kp;
                if (chance(10)) osd_pause = ~osd_pause;
                downloading = chance(8);
            end
            default: begin
                board_joy = '0;
                r = $random(seed);
                keys = '0;
                keys.key_reset = chance(40);
                keys.key_gfx = r[3:0];
                downloading = 1'b0;
            end
        endcase
    endtask

    task automatic run_phase(input int mode, input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_inputs(mode);
            run_cycle();
        end
    endtask

    initial begin
        seed          = 19;
        seen_pause    = 0;
        seen_soft_rst = 0;
        rst           = 1'b1;
        board_joy     = '0;
        keys          = '0;
        cfg           = '0;
        osd_pause     = 1'b0;
        downloading   = 1'b0;

        run_cycle();
        run_cycle();
        rst = 1'b0;
        wait_outputs_idle();

        // idle levels straight after reset
        check_value("game", 64'(game), {15'h0, {49{1'b1}}});
        check_value("game_pause", 64'(game_pause), 64'h0);
        check_value("soft_rst", 64'(soft_rst), 64'h0);
        check_value("gfx_en", 64'(gfx_en), 64'hf);

        // every rot_control, flip and en4way combination
        for (int c = 0; c < 8; c++) begin
            cfg = c[2:0];
            run_phase(0, 200);
        end
        run_phase(1, 1000);
        run_phase(2, 1000);
        run_phase(3, 1000);

        board_joy = '0;
        keys      = '0;
        for (int i = 0; i < 4; i++) run_cycle();

        if (seen_pause > 0 && seen_soft_rst > 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("pause or soft reset never became active during the run");
            $display("TEST FAIL");
            $fatal(1, "stimulus did not reach every control output");
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/board_pkg.sv
logic/four_way_filter.sv
logic/input_mapper.sv
logic/board_control.sv
logic/board_inputs.sv
tests/board_control_assert.sv
tests/board_inputs_tb.sv

// ==== Bender.yml ====
package:
  name: board_inputs

sources:
  # RTL, package first
  - logic/board_pkg.sv
  - logic/four_way_filter.sv
  - logic/input_mapper.sv
  - logic/board_control.sv
  - logic/board_inputs.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - tests/board_control_assert.sv
      - tests/board_inputs_tb.sv

# top levels
#   RTL:       board_inputs
#   testbench: board_inputs_tb
#
# the same order is kept in tb.f
